// File: Bender.yml
package:
  name: memsplit

sources:
  - hdl/memsplit_pkg.sv
  - hdl/dual_port_ram.sv
  - hdl/data_port_arbiter.sv
  - hdl/bus_unit.sv
  - hdl/memsplit_top.sv
  - target: test
    files:
      - verification/memsplit_props.sv
      - verification/memsplit_tb.sv

// File: filelist.f
hdl/memsplit_pkg.sv
hdl/dual_port_ram.sv
hdl/data_port_arbiter.sv
hdl/bus_unit.sv
hdl/memsplit_top.sv
verification/memsplit_props.sv
verification/memsplit_tb.sv

// File: hdl/bus_unit.sv
`timescale 1ns/100ps
`default_nettype none

module bus_unit
#(
	parameter int mem_words = memsplit_pkg::mem_words_default
)
(
	input wire clk_i
	, input wire srst_i

	, input wire instr_req_i
	, input wire instr_we_i
	, input wire [memsplit_pkg::addr_width-1:0] instr_addr_i
	, input wire [memsplit_pkg::be_width-1:0] instr_be_i
	, input wire [memsplit_pkg::data_width-1:0] instr_wdata_i
	, output logic instr_ack_o
	, output logic instr_resp_o
	, output logic [memsplit_pkg::data_width-1:0] instr_rdata_o

	, input wire data_req_i
	, input wire data_we_i
	, input wire [memsplit_pkg::addr_width-1:0] data_addr_i
	, input wire [memsplit_pkg::be_width-1:0] data_be_i
	, input wire [memsplit_pkg::data_width-1:0] data_wdata_i
	, output logic data_ack_o
	, output logic data_resp_o
	, output logic [memsplit_pkg::data_width-1:0] data_rdata_o

	, input wire [memsplit_pkg::data_width-1:0] gpio_i
	, output logic [memsplit_pkg::data_width-1:0] gpio_o
);

import memsplit_pkg::*;

localparam int ram_aw = $clog2(mem_words);

bus_addr_u instr_addr;
bus_addr_u data_addr;
logic [25:0] instr_word;
logic [25:0] data_word;
logic instr_rd;
logic data_rd;
logic is_ram;
logic is_gpio;
logic gpio_wr;
logic gpio_rd;
logic rd_ram_q;
logic rd_gpio_q;
logic [data_width-1:0] gpio_out_q;
logic [data_width-1:0] gpio_rdata_q;
logic [data_width-1:0] ram_b_rdata;

assign instr_addr = instr_addr_i;
assign data_addr = data_addr_i;

// deeper RAMs reach into the unused field above word_index.
assign instr_word = {instr_addr.mem.unused, instr_addr.mem.word_index};
assign data_word = {data_addr.mem.unused, data_addr.mem.word_index};

// both ports accept immediately, instruction writes are dropped.
assign instr_ack_o = instr_req_i;
assign data_ack_o = data_req_i;
assign instr_rd = instr_req_i & ~instr_we_i;
assign data_rd = data_req_i & ~data_we_i;

assign is_ram = (data_addr.mem.region == region_ram);
assign is_gpio = (data_addr.periph.region == region_gpio);
assign gpio_wr = data_req_i & data_we_i & is_gpio
	& (data_addr.periph.reg_index == gpio_reg_out);
assign gpio_rd = data_rd & is_gpio;

dual_port_ram
#(
	.words(mem_words)
) i_ram
(
	.clk_i(clk_i)
	, .a_en_i(instr_rd)
	, .a_addr_i(instr_word[ram_aw-1:0])
	, .a_rdata_o(instr_rdata_o)
	, .b_en_i(data_req_i & is_ram)
	, .b_we_i(data_we_i)
	, .b_be_i(data_be_i)
	, .b_addr_i(data_word[ram_aw-1:0])
	, .b_wdata_i(data_wdata_i)
	, .b_rdata_o(ram_b_rdata)
);

// **************************************************
// gpio registers.
// **************************************************
always_ff @(posedge clk_i)
	begin
	if (srst_i)
		gpio_out_q <= '0;
	else if (gpio_wr)
		begin
		for (int i = 0; i < be_width; i++)
			begin
			if (data_be_i[i])
				gpio_out_q[8*i +: 8] <= data_wdata_i[8*i +: 8];
			end
		end
	end

assign gpio_o = gpio_out_q;

// gpio_i is sampled on the accepting edge.
always_ff @(posedge clk_i)
	begin
	if (gpio_rd)
		begin
		case (data_addr.periph.reg_index)
			gpio_reg_out: gpio_rdata_q <= gpio_out_q;
			gpio_reg_in: gpio_rdata_q <= gpio_i;
			default: gpio_rdata_q <= '0;
		endcase
		end
	end

// **************************************************
// response and read source.
// **************************************************
always_ff @(posedge clk_i)
	begin
	if (srst_i)
		begin
		instr_resp_o <= 1'b0;
		data_resp_o <= 1'b0;
		rd_ram_q <= 1'b0;
		rd_gpio_q <= 1'b0;
		end
	else
		begin
		instr_resp_o <= instr_rd;
		data_resp_o <= data_rd;
		rd_ram_q <= data_rd & is_ram;
		rd_gpio_q <= gpio_rd;
		end
	end

// unmapped reads fall through to zero.
always_comb
	begin
	data_rdata_o = '0;
	if (rd_ram_q)
		data_rdata_o = ram_b_rdata;
	else if (rd_gpio_q)
		data_rdata_o = gpio_rdata_q;
	end

endmodule

`default_nettype wire

// File: hdl/data_port_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module data_port_arbiter
(
	input wire clk_i
	, input wire srst_i

	, input wire dbg_req_i
	, input wire dbg_we_i
	, input wire [memsplit_pkg::addr_width-1:0] dbg_addr_i
	, input wire [memsplit_pkg::be_width-1:0] dbg_be_i
	, input wire [memsplit_pkg::data_width-1:0] dbg_wdata_i
	, output logic dbg_ack_o
	, output logic dbg_resp_o
	, output logic [memsplit_pkg::data_width-1:0] dbg_rdata_o

	, input wire cpu_req_i
	, input wire cpu_we_i
	, input wire [memsplit_pkg::addr_width-1:0] cpu_addr_i
	, input wire [memsplit_pkg::be_width-1:0] cpu_be_i
	, input wire [memsplit_pkg::data_width-1:0] cpu_wdata_i
	, output logic cpu_ack_o
	, output logic cpu_resp_o
	, output logic [memsplit_pkg::data_width-1:0] cpu_rdata_o

	, output logic bus_req_o
	, output logic bus_we_o
	, output logic [memsplit_pkg::addr_width-1:0] bus_addr_o
	, output logic [memsplit_pkg::be_width-1:0] bus_be_o
	, output logic [memsplit_pkg::data_width-1:0] bus_wdata_o
	, input wire bus_ack_i
	, input wire bus_resp_i
	, input wire [memsplit_pkg::data_width-1:0] bus_rdata_i
);

logic dbg_grant;
logic cpu_grant;
logic dbg_rd_q;
logic cpu_rd_q;

// debug has fixed priority.
assign dbg_grant = dbg_req_i;
assign cpu_grant = cpu_req_i & ~dbg_req_i;

assign dbg_ack_o = dbg_grant & bus_ack_i;
assign cpu_ack_o = cpu_grant & bus_ack_i;

always_comb
	begin
	bus_req_o = 1'b0;
	bus_we_o = 1'b0;
	bus_addr_o = '0;
	bus_be_o = '0;
	bus_wdata_o = '0;
	if (dbg_grant)
		begin
		bus_req_o = 1'b1;
		bus_we_o = dbg_we_i;
		bus_addr_o = dbg_addr_i;
		bus_be_o = dbg_be_i;
		bus_wdata_o = dbg_wdata_i;
		end
	else if (cpu_grant)
		begin
		bus_req_o = 1'b1;
		bus_we_o = cpu_we_i;
		bus_addr_o = cpu_addr_i;
		bus_be_o = cpu_be_i;
		bus_wdata_o = cpu_wdata_i;
		end
	end

// **************************************************
// response owner, one cycle behind the accepted read.
// **************************************************
always_ff @(posedge clk_i)
	begin
	if (srst_i)
		begin
		dbg_rd_q <= 1'b0;
		cpu_rd_q <= 1'b0;
		end
	else
		begin
		dbg_rd_q <= dbg_ack_o & ~dbg_we_i;
		cpu_rd_q <= cpu_ack_o & ~cpu_we_i;
		end
	end

always_comb
	begin
	dbg_resp_o = 1'b0;
	dbg_rdata_o = '0;
	cpu_resp_o = 1'b0;
	cpu_rdata_o = '0;
	if (dbg_rd_q)
		begin
		dbg_resp_o = bus_resp_i;
		dbg_rdata_o = bus_rdata_i;
		end
	else if (cpu_rd_q)
		begin
		cpu_resp_o = bus_resp_i;
		cpu_rdata_o = bus_rdata_i;
		end
	end

endmodule

`default_nettype wire

// File: hdl/dual_port_ram.sv
`timescale 1ns/100ps
`default_nettype none

module dual_port_ram
#(
	parameter int words = memsplit_pkg::mem_words_default
)
(
	input wire clk_i

	, input wire a_en_i
	, input wire [$clog2(words)-1:0] a_addr_i
	, output logic [memsplit_pkg::data_width-1:0] a_rdata_o

	, input wire b_en_i
	, input wire b_we_i
	, input wire [memsplit_pkg::be_width-1:0] b_be_i
	, input wire [$clog2(words)-1:0] b_addr_i
	, input wire [memsplit_pkg::data_width-1:0] b_wdata_i
	, output logic [memsplit_pkg::data_width-1:0] b_rdata_o
);

import memsplit_pkg::*;

logic [data_width-1:0] mem [words];

// port a, read only.
// a same-cycle write on port b is not seen here yet.
always_ff @(posedge clk_i)
	begin
	if (a_en_i)
		a_rdata_o <= mem[a_addr_i];
	end

// **************************************************
// port b, read or byte-enabled write.
// **************************************************
always_ff @(posedge clk_i)
	begin
	if (b_en_i)
		begin
		if (b_we_i)
			begin
			for (int i = 0; i < be_width; i++)
				begin
				if (b_be_i[i])
					mem[b_addr_i][8*i +: 8] <= b_wdata_i[8*i +: 8];
				end
			end
		else
			b_rdata_o <= mem[b_addr_i];
		end
	end

endmodule

`default_nettype wire

// File: hdl/memsplit_pkg.sv
`default_nettype none

package memsplit_pkg;

// **************************************************
// bus geometry.
// **************************************************
localparam int data_width = 32;
localparam int addr_width = 32;
localparam int be_width = data_width / 8;
localparam int mem_words_default = 1024;

// **************************************************
// address map, selected by addr[31:28].
// **************************************************
localparam logic [3:0] region_ram = 4'h0;
localparam logic [3:0] region_gpio = 4'h1;

// gpio register indices.
localparam logic [3:0] gpio_reg_out = 4'd0;
localparam logic [3:0] gpio_reg_in = 4'd1;

// one bus address, seen either as a memory word or as a peripheral register.
typedef union packed
	{
	struct packed
		{
		logic [3:0] region;
		logic [15:0] unused;
		logic [9:0] word_index;
		logic [1:0] byte_offset;
		} mem;
	struct packed
		{
		logic [3:0] region;
		logic [21:0] unused;
		logic [3:0] reg_index;
		logic [1:0] byte_offset;
		} periph;
	} bus_addr_u;

endpackage

`default_nettype wire

// File: hdl/memsplit_top.sv
`timescale 1ns/100ps
`default_nettype none

module memsplit_top
#(
	parameter int mem_words = memsplit_pkg::mem_words_default
)
(
	input wire clk_i
	, input wire srst_i

	, input wire cpu_instr_req_i
	, input wire cpu_instr_we_i
	, input wire [memsplit_pkg::addr_width-1:0] cpu_instr_addr_i
	, input wire [memsplit_pkg::be_width-1:0] cpu_instr_be_i
	, input wire [memsplit_pkg::data_width-1:0] cpu_instr_wdata_i
	, output logic cpu_instr_ack_o
	, output logic cpu_instr_resp_o
	, output logic [memsplit_pkg::data_width-1:0] cpu_instr_rdata_o

	, input wire cpu_data_req_i
	, input wire cpu_data_we_i
	, input wire [memsplit_pkg::addr_width-1:0] cpu_data_addr_i
	, input wire [memsplit_pkg::be_width-1:0] cpu_data_be_i
	, input wire [memsplit_pkg::data_width-1:0] cpu_data_wdata_i
	, output logic cpu_data_ack_o
	, output logic cpu_data_resp_o
	, output logic [memsplit_pkg::data_width-1:0] cpu_data_rdata_o

	, input wire dbg_req_i
	, input wire dbg_we_i
	, input wire [memsplit_pkg::addr_width-1:0] dbg_addr_i
	, input wire [memsplit_pkg::be_width-1:0] dbg_be_i
	, input wire [memsplit_pkg::data_width-1:0] dbg_wdata_i
	, output logic dbg_ack_o
	, output logic dbg_resp_o
	, output logic [memsplit_pkg::data_width-1:0] dbg_rdata_o

	, input wire [memsplit_pkg::data_width-1:0] gpio_i
	, output logic [memsplit_pkg::data_width-1:0] gpio_o
);

import memsplit_pkg::*;

// arbitrated data port.
logic bus_req;
logic bus_we;
logic [addr_width-1:0] bus_addr;
logic [be_width-1:0] bus_be;
logic [data_width-1:0] bus_wdata;
logic bus_ack;
logic bus_resp;
logic [data_width-1:0] bus_rdata;

data_port_arbiter i_arbiter
(
	.clk_i(clk_i)
	, .srst_i(srst_i)
	, .dbg_req_i(dbg_req_i)
	, .dbg_we_i(dbg_we_i)
	, .dbg_addr_i(dbg_addr_i)
	, .dbg_be_i(dbg_be_i)
	, .dbg_wdata_i(dbg_wdata_i)
	, .dbg_ack_o(dbg_ack_o)
	, .dbg_resp_o(dbg_resp_o)
	, .dbg_rdata_o(dbg_rdata_o)
	, .cpu_req_i(cpu_data_req_i)
	, .cpu_we_i(cpu_data_we_i)
	, .cpu_addr_i(cpu_data_addr_i)
	, .cpu_be_i(cpu_data_be_i)
	, .cpu_wdata_i(cpu_data_wdata_i)
	, .cpu_ack_o(cpu_data_ack_o)
	, .cpu_resp_o(cpu_data_resp_o)
	, .cpu_rdata_o(cpu_data_rdata_o)
	, .bus_req_o(bus_req)
	, .bus_we_o(bus_we)
	, .bus_addr_o(bus_addr)
	, .bus_be_o(bus_be)
	, .bus_wdata_o(bus_wdata)
	, .bus_ack_i(bus_ack)
	, .bus_resp_i(bus_resp)
	, .bus_rdata_i(bus_rdata)
);

bus_unit
#(
	.mem_words(mem_words)
) i_bus_unit
(
	.clk_i(clk_i)
	, .srst_i(srst_i)
	, .instr_req_i(cpu_instr_req_i)
	, .instr_we_i(cpu_instr_we_i)
	, .instr_addr_i(cpu_instr_addr_i)
	, .instr_be_i(cpu_instr_be_i)
	, .instr_wdata_i(cpu_instr_wdata_i)
	, .instr_ack_o(cpu_instr_ack_o)
	, .instr_resp_o(cpu_instr_resp_o)
	, .instr_rdata_o(cpu_instr_rdata_o)
	, .data_req_i(bus_req)
	, .data_we_i(bus_we)
	, .data_addr_i(bus_addr)
	, .data_be_i(bus_be)
	, .data_wdata_i(bus_wdata)
	, .data_ack_o(bus_ack)
	, .data_resp_o(bus_resp)
	, .data_rdata_o(bus_rdata)
	, .gpio_i(gpio_i)
	, .gpio_o(gpio_o)
);

endmodule

`default_nettype wire

// File: verification/memsplit_props.sv
`timescale 1ns/100ps
`default_nettype none

module memsplit_props
(
	input wire clk_i
	, input wire srst_i
	, input wire dbg_req_i
	, input wire cpu_req_i
	, input wire dbg_ack_i
	, input wire cpu_ack_i
	, input wire bus_resp_i
	, input wire dbg_resp_i
	, input wire cpu_resp_i
);

int fail_count = 0;

// only the granted master sees ack.
a_single_ack: assert property (@(posedge clk_i) disable iff (srst_i)
	!(dbg_ack_i && cpu_ack_i))
	else
		begin
		fail_count++;
		$error("ack reached both masters in the same cycle.");
		end

// a bus response is steered to one master.
a_resp_owner: assert property (@(posedge clk_i) disable iff (srst_i)
	bus_resp_i |-> (dbg_resp_i ^ cpu_resp_i))
	else
		begin
		fail_count++;
		$error("bus response did not reach exactly one master.");
		end

a_ack_needs_req: assert property (@(posedge clk_i) disable iff (srst_i)
	(!dbg_ack_i || dbg_req_i) && (!cpu_ack_i || cpu_req_i))
	else
		begin
		fail_count++;
		$error("a master got ack without a request.");
		end

endmodule

`default_nettype wire

// File: verification/memsplit_tb.sv
`timescale 1ns/100ps
`default_nettype none

module memsplit_tb;

import memsplit_pkg::*;

typedef enum int {port_instr, port_cpu, port_dbg} port_e;

logic clk_i;
logic srst_i;

logic cpu_instr_req_i;
logic cpu_instr_we_i;
logic [addr_width-1:0] cpu_instr_addr_i;
logic [be_width-1:0] cpu_instr_be_i;
logic [data_width-1:0] cpu_instr_wdata_i;
logic cpu_instr_ack_o;
logic cpu_instr_resp_o;
logic [data_width-1:0] cpu_instr_rdata_o;

logic cpu_data_req_i;
logic cpu_data_we_i;
logic [addr_width-1:0] cpu_data_addr_i;
logic [be_width-1:0] cpu_data_be_i;
logic [data_width-1:0] cpu_data_wdata_i;
logic cpu_data_ack_o;
logic cpu_data_resp_o;
logic [data_width-1:0] cpu_data_rdata_o;

logic dbg_req_i;
logic dbg_we_i;
logic [addr_width-1:0] dbg_addr_i;
logic [be_width-1:0] dbg_be_i;
logic [data_width-1:0] dbg_wdata_i;
logic dbg_ack_o;
logic dbg_resp_o;
logic [data_width-1:0] dbg_rdata_o;

logic [data_width-1:0] gpio_i;
logic [data_width-1:0] gpio_o;

integer seed;
int errors;

memsplit_top i_dut (.*);

bind data_port_arbiter memsplit_props i_props
(
	.clk_i(clk_i)
	, .srst_i(srst_i)
	, .dbg_req_i(dbg_req_i)
	, .cpu_req_i(cpu_req_i)
	, .dbg_ack_i(dbg_ack_o)
	, .cpu_ack_i(cpu_ack_o)
	, .bus_resp_i(bus_resp_i)
	, .dbg_resp_i(dbg_resp_o)
	, .cpu_resp_i(cpu_resp_o)
);

initial clk_i = 1'b0;
always #20 clk_i = ~clk_i;

// **************************************************
// compare tasks.
// **************************************************
task automatic compare_word(input string name, input logic [data_width-1:0] actual,
	input logic [data_width-1:0] expected);
	if (actual !== expected)
		begin
		errors++;
		$display("error: %s = %h, expected %h", name, actual, expected);
		end
endtask

task automatic compare_gpio(input string name, input logic [data_width-1:0] actual,
	input logic [data_width-1:0] expected);
	if (actual !== expected)
		begin
		errors++;
		$display("error: %s = %h, expected %h", name, actual, expected);
		end
endtask

task automatic compare_bit(input string name, input logic actual, input logic expected);
	if (actual !== expected)
		begin
		errors++;
		$display("error: %s = %h, expected %h", name, actual, expected);
		end
endtask

// **************************************************
// port access helpers.
// **************************************************
function automatic string port_name(input port_e p);
	case (p)
		port_instr: return "cpu_instr";
		port_cpu: return "cpu_data";
		default: return "dbg";
	endcase
endfunction

function automatic logic ack_of(input port_e p);
	case (p)
		port_instr: return cpu_instr_ack_o;
		port_cpu: return cpu_data_ack_o;
		default: return dbg_ack_o;
	endcase
endfunction

function automatic logic resp_of(input port_e p);
	case (p)
		port_instr: return cpu_instr_resp_o;
		port_cpu: return cpu_data_resp_o;
		default: return dbg_resp_o;
	endcase
endfunction

function automatic logic [data_width-1:0] rdata_of(input port_e p);
	case (p)
		port_instr: return cpu_instr_rdata_o;
		port_cpu: return cpu_data_rdata_o;
		default: return dbg_rdata_o;
	endcase
endfunction

function automatic logic [addr_width-1:0] ram_addr(input int idx);
	return {region_ram, 16'h0, idx[9:0], 2'b00};
endfunction

function automatic logic [addr_width-1:0] gpio_addr(input logic [3:0] idx);
	return {region_gpio, 22'h0, idx, 2'b00};
endfunction

// expected word after a byte-enabled write.
function automatic logic [data_width-1:0] merge_bytes(input logic [data_width-1:0] old_word,
	input logic [data_width-1:0] new_word, input logic [be_width-1:0] be);
	logic [data_width-1:0] mask;
	mask = '0;
	for (int i = 0; i < be_width; i++)
		begin
		if (be[i])
			mask = mask | (32'hff << (8 * i));
		end
	return (old_word & ~mask) | (new_word & mask);
endfunction

task automatic drive(input port_e p, input logic req, input logic we,
	input logic [addr_width-1:0] addr, input logic [be_width-1:0] be,
	input logic [data_width-1:0] wdata);
	case (p)
		port_instr:
			begin
			cpu_instr_req_i = req;
			cpu_instr_we_i = we;
			cpu_instr_addr_i = addr;
			cpu_instr_be_i = be;
			cpu_instr_wdata_i = wdata;
			end
		port_cpu:
			begin
			cpu_data_req_i = req;
			cpu_data_we_i = we;
			cpu_data_addr_i = addr;
			cpu_data_be_i = be;
			cpu_data_wdata_i = wdata;
			end
		default:
			begin
			dbg_req_i = req;
			dbg_we_i = we;
			dbg_addr_i = addr;
			dbg_be_i = be;
			dbg_wdata_i = wdata;
			end
	endcase
endtask

task automatic idle_port(input port_e p);
	drive(p, 1'b0, 1'b0, '0, '0, '0);
endtask

// ack is combinational from the inputs and stable at the rising edge.
task automatic wait_ack(input port_e p, output logic seen);
	int waits;
	waits = 0;
	@(posedge clk_i);
	while (!ack_of(p) && waits < 20)
		begin
		waits++;
		@(posedge clk_i);
		end
	seen = ack_of(p);
	if (!seen)
		begin
		errors++;
		$display("timeout: the %s port never acknowledged its request", port_name(p));
		end
endtask

// one request on a port where a read also waits for resp and returns rdata.
task automatic access(input port_e p, input logic we, input logic [addr_width-1:0] addr,
	input logic [be_width-1:0] be, input logic [data_width-1:0] wdata,
	output logic [data_width-1:0] rdata);
	int waits;
	logic seen;
	rdata = '0;
	@(negedge clk_i);
	drive(p, 1'b1, we, addr, be, wdata);
	wait_ack(p, seen);
	@(negedge clk_i);
	idle_port(p);
	if (!we && seen)
		begin
		compare_bit({port_name(p), "_resp_o"}, resp_of(p), 1'b1);
		waits = 0;
		while (!resp_of(p) && waits < 20)
			begin
			waits++;
			@(negedge clk_i);
			end
		if (resp_of(p))
			rdata = rdata_of(p);
		else
			begin
			errors++;
			$display("timeout: the %s port never returned read data", port_name(p));
			end
		end
endtask

// **************************************************
// directed tests.
// **************************************************
task automatic reset_values();
	// reads held through reset must leave every registered output low.
	compare_bit("cpu_instr_resp_o", cpu_instr_resp_o, 1'b0);
	compare_bit("cpu_data_resp_o", cpu_data_resp_o, 1'b0);
	compare_bit("dbg_resp_o", dbg_resp_o, 1'b0);
	compare_gpio("gpio_o", gpio_o, '0);
	idle_port(port_instr);
	idle_port(port_cpu);
	idle_port(port_dbg);
	srst_i = 1'b0;
	@(negedge clk_i);
	compare_bit("cpu_instr_ack_o", cpu_instr_ack_o, 1'b0);
	compare_bit("cpu_instr_resp_o", cpu_instr_resp_o, 1'b0);
	compare_bit("cpu_data_ack_o", cpu_data_ack_o, 1'b0);
	compare_bit("cpu_data_resp_o", cpu_data_resp_o, 1'b0);
	compare_bit("dbg_ack_o", dbg_ack_o, 1'b0);
	compare_bit("dbg_resp_o", dbg_resp_o, 1'b0);
	compare_gpio("gpio_o", gpio_o, '0);
endtask

task automatic cpu_word_roundtrip();
	logic [data_width-1:0] words [8];
	logic [data_width-1:0] rdata;
	for (int i = 0; i < 8; i++)
		begin
		words[i] = $random(seed);
		access(port_cpu, 1'b1, ram_addr(16 + i), '1, words[i], rdata);
		end
	for (int i = 0; i < 8; i++)
		begin
		access(port_cpu, 1'b0, ram_addr(16 + i), '0, '0, rdata);
		compare_word("cpu_data_rdata_o", rdata, words[i]);
		access(port_instr, 1'b0, ram_addr(16 + i), '0, '0, rdata);
		compare_word("cpu_instr_rdata_o", rdata, words[i]);
		end
endtask

task automatic dbg_byte_merge();
	logic [data_width-1:0] expected;
	logic [data_width-1:0] wdata;
	logic [data_width-1:0] rdata;
	logic [be_width-1:0] be;
	expected = $random(seed);
	access(port_dbg, 1'b1, ram_addr(40), '1, expected, rdata);
	for (int i = 0; i < 6; i++)
		begin
		wdata = $random(seed);
		be = $random(seed);
		access(port_dbg, 1'b1, ram_addr(40), be, wdata, rdata);
		expected = merge_bytes(expected, wdata, be);
		access(port_dbg, 1'b0, ram_addr(40), '0, '0, rdata);
		compare_word("dbg_rdata_o", rdata, expected);
		end
endtask

task automatic arbitration_order();
	logic [data_width-1:0] dbg_word;
	logic [data_width-1:0] cpu_word;
	logic seen;
	dbg_word = $random(seed);
	cpu_word = $random(seed);
	// debug keeps its write request up for three cycles.
	@(negedge clk_i);
	drive(port_dbg, 1'b1, 1'b1, ram_addr(60), '1, dbg_word);
	drive(port_cpu, 1'b1, 1'b1, ram_addr(61), '1, cpu_word);
	repeat (3)
		begin
		@(posedge clk_i);
		compare_bit("dbg_ack_o", dbg_ack_o, 1'b1);
		compare_bit("cpu_data_ack_o", cpu_data_ack_o, 1'b0);
		end
	@(negedge clk_i);
	idle_port(port_dbg);
	wait_ack(port_cpu, seen);
	@(negedge clk_i);
	idle_port(port_cpu);

	// debug read followed by a cpu read one cycle later.
	@(negedge clk_i);
	drive(port_dbg, 1'b1, 1'b0, ram_addr(60), '0, '0);
	drive(port_cpu, 1'b1, 1'b0, ram_addr(61), '0, '0);
	wait_ack(port_dbg, seen);
	@(negedge clk_i);
	compare_bit("dbg_resp_o", dbg_resp_o, 1'b1);
	compare_bit("cpu_data_resp_o", cpu_data_resp_o, 1'b0);
	compare_word("dbg_rdata_o", dbg_rdata_o, dbg_word);
	idle_port(port_dbg);
	wait_ack(port_cpu, seen);
	@(negedge clk_i);
	compare_bit("cpu_data_resp_o", cpu_data_resp_o, 1'b1);
	compare_bit("dbg_resp_o", dbg_resp_o, 1'b0);
	compare_word("cpu_data_rdata_o", cpu_data_rdata_o, cpu_word);
	idle_port(port_cpu);
endtask

task automatic gpio_and_unmapped();
	logic [data_width-1:0] out_word;
	logic [data_width-1:0] in_word;
	logic [data_width-1:0] rdata;
	out_word = $random(seed);
	in_word = $random(seed);
	access(port_cpu, 1'b1, gpio_addr(gpio_reg_out), '1, out_word, rdata);
	compare_gpio("gpio_o", gpio_o, out_word);
	access(port_cpu, 1'b0, gpio_addr(gpio_reg_out), '0, '0, rdata);
	compare_word("cpu_data_rdata_o", rdata, out_word);
	gpio_i = in_word;
	access(port_dbg, 1'b0, gpio_addr(gpio_reg_in), '0, '0, rdata);
	compare_word("dbg_rdata_o", rdata, in_word);
	// region 2 aliases a RAM word that holds data but must still read zero.
	access(port_cpu, 1'b0, 32'h2000_0040, '0, '0, rdata);
	compare_word("cpu_data_rdata_o", rdata, '0);
endtask

initial
	begin
	seed = 37;
	errors = 0;
	srst_i = 1'b1;
	gpio_i = '0;
	drive(port_instr, 1'b1, 1'b0, ram_addr(0), '0, '0);
	drive(port_cpu, 1'b1, 1'b0, ram_addr(0), '0, '0);
	drive(port_dbg, 1'b1, 1'b0, ram_addr(0), '0, '0);
	repeat (2) @(posedge clk_i);
	@(negedge clk_i);

	reset_values();
	cpu_word_roundtrip();
	dbg_byte_merge();
	arbitration_order();
	gpio_and_unmapped();

	repeat (2) @(negedge clk_i);
	errors += i_dut.i_arbiter.i_props.fail_count;
	$display("errors: %0d", errors);
	if (errors == 0)
		$display("ALL TESTS PASSED");
	else
		$display("SOME TESTS FAILED");
	$finish;
	end

endmodule

`default_nettype wire
